//--- logic/imem_lane_sram.sv
`timescale 1ns/1ps

module imem_lane_sram (
    input  logic                         clk_i,
    input  logic                         rv_rst_ni,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [soc_map_pkg::XLEN-1:0] addr_i,
    input  logic [soc_map_pkg::XLEN-1:0] wdata_i,
    output logic [soc_map_pkg::XLEN-1:0] rdata_o
);

    logic [soc_map_pkg::MEM_AW-1:0] word_idx;
    logic [1:0]                     offset;
    logic [1:0]                     offset_q;
    logic [7:0]                     lane_dout [soc_map_pkg::WORD_BYTES];

    assign word_idx = addr_i[soc_map_pkg::MEM_AW+1:2];
    assign offset   = addr_i[1:0];

    for (genvar k = 0; k < soc_map_pkg::WORD_BYTES; k++) begin : g_lane
        logic [7:0]                     bank [soc_map_pkg::MEM_WORDS];
        logic [soc_map_pkg::MEM_AW-1:0] lane_addr;
        logic [1:0]                     wsel;

        // Lanes below the offset hold bytes of the next word, top wraps
        assign lane_addr = word_idx + soc_map_pkg::MEM_AW'(2'(k) < offset);
        assign wsel      = 2'(k) - offset;

        always_ff @(posedge clk_i) begin
            if (req_i && we_i) begin
                bank[lane_addr] <= wdata_i[8*wsel +: 8];
            end else if (req_i) begin
                lane_dout[k] <= bank[lane_addr];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            offset_q <= 2'b00;
        end else if (req_i && !we_i) begin
            offset_q <= offset;
        end
    end

    // Rotate lanes back so byte 0 is the addressed byte
    for (genvar j = 0; j < soc_map_pkg::WORD_BYTES; j++) begin : g_rot
        assign rdata_o[8*j +: 8] = lane_dout[2'(j) + offset_q];
    end

endmodule

//--- logic/pim_port.sv
`timescale 1ns/1ps

module pim_port (
    input  logic                         clk_i,
    input  logic                         rv_rst_ni,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [soc_map_pkg::XLEN-1:0] addr_i,
    input  logic [soc_map_pkg::XLEN-1:0] wdata_i,
    output logic [soc_map_pkg::XLEN-1:0] rdata_o,
    output logic [soc_map_pkg::XLEN-1:0] pim_addr_o,
    output logic [soc_map_pkg::XLEN-1:0] pim_wr_o,
    input  logic [soc_map_pkg::XLEN-1:0] pim_rd_i
);

    // Controller pins hold the last write
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else if (req_i && we_i) begin
            pim_addr_o <= addr_i;
            pim_wr_o   <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            rdata_o <= pim_rd_i;
        end
    end

endmodule

//--- logic/pim_soc_top.sv
`timescale 1ns/1ps

module pim_soc_top (
    input  logic                         clk_i,
    input  logic                         rv_rst_ni,
    input  logic                         sclk_i,
    input  logic                         cs_i,
    input  logic                         mosi_i,
    output logic                         miso_o,
    output logic [soc_map_pkg::XLEN-1:0] pim_addr_o,
    output logic [soc_map_pkg::XLEN-1:0] pim_wr_o,
    input  logic [soc_map_pkg::XLEN-1:0] pim_rd_i
);

    logic                         bus_req;
    logic                         bus_we;
    logic [soc_map_pkg::XLEN-1:0] bus_addr;
    logic [soc_map_pkg::XLEN-1:0] bus_wdata;
    logic [soc_map_pkg::XLEN-1:0] bus_rdata;
    logic                         imem_req;
    logic                         imem_we;
    logic                         dmem_req;
    logic                         dmem_we;
    logic                         buf_req;
    logic                         buf_we;
    logic                         pim_req;
    logic                         pim_we;
    logic [soc_map_pkg::XLEN-1:0] mem_addr;
    logic [soc_map_pkg::XLEN-1:0] mem_wdata;
    logic [soc_map_pkg::XLEN-1:0] imem_rdata;
    logic [soc_map_pkg::XLEN-1:0] dmem_rdata;
    logic [soc_map_pkg::XLEN-1:0] buf_rdata;
    logic [soc_map_pkg::XLEN-1:0] pim_rdata;

    spi_bus_bridge spi_0 (
        .clk_i       (clk_i),
        .rv_rst_ni   (rv_rst_ni),
        .sclk_i      (sclk_i),
        .cs_i        (cs_i),
        .mosi_i      (mosi_i),
        .miso_o      (miso_o),
        .bus_req_o   (bus_req),
        .bus_we_o    (bus_we),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_rdata_i (bus_rdata)
    );

    sys_bus bus_0 (
        .clk_i        (clk_i),
        .rv_rst_ni    (rv_rst_ni),
        .bus_req_i    (bus_req),
        .bus_we_i     (bus_we),
        .bus_addr_i   (bus_addr),
        .bus_wdata_i  (bus_wdata),
        .bus_rdata_o  (bus_rdata),
        .imem_req_o   (imem_req),
        .imem_we_o    (imem_we),
        .dmem_req_o   (dmem_req),
        .dmem_we_o    (dmem_we),
        .buf_req_o    (buf_req),
        .buf_we_o     (buf_we),
        .pim_req_o    (pim_req),
        .pim_we_o     (pim_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .imem_rdata_i (imem_rdata),
        .dmem_rdata_i (dmem_rdata),
        .buf_rdata_i  (buf_rdata),
        .pim_rdata_i  (pim_rdata)
    );

    imem_lane_sram imem_0 (
        .clk_i     (clk_i),
        .rv_rst_ni (rv_rst_ni),
        .req_i     (imem_req),
        .we_i      (imem_we),
        .addr_i    (mem_addr),
        .wdata_i   (mem_wdata),
        .rdata_o   (imem_rdata)
    );

    // Word index of the byte address
    word_sram dmem_0 (
        .clk_i   (clk_i),
        .req_i   (dmem_req),
        .we_i    (dmem_we),
        .addr_i  (mem_addr[soc_map_pkg::MEM_AW+1:2]),
        .wdata_i (mem_wdata),
        .rdata_o (dmem_rdata)
    );

    word_sram buf_0 (
        .clk_i   (clk_i),
        .req_i   (buf_req),
        .we_i    (buf_we),
        .addr_i  (mem_addr[soc_map_pkg::MEM_AW+1:2]),
        .wdata_i (mem_wdata),
        .rdata_o (buf_rdata)
    );

    pim_port pim_0 (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .req_i      (pim_req),
        .we_i       (pim_we),
        .addr_i     (mem_addr),
        .wdata_i    (mem_wdata),
        .rdata_o    (pim_rdata),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o),
        .pim_rd_i   (pim_rd_i)
    );

endmodule

//--- logic/soc_map_pkg.sv
package soc_map_pkg;

    // Bus geometry
    localparam int XLEN       = 32;
    localparam int WORD_BYTES = 4;

    // Every SRAM has the same depth
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // Region bases, selected by address bits 31:28
    localparam logic [XLEN-1:0] IMEM_BASE = 32'h1000_0000;
    localparam logic [XLEN-1:0] DMEM_BASE = 32'h2000_0000;
    localparam logic [XLEN-1:0] BUF_BASE  = 32'h3000_0000;
    localparam logic [XLEN-1:0] PIM_BASE  = 32'h4000_0000;

    localparam int REGION_SHIFT = 28;

    typedef enum logic [2:0] {
        REG_IMEM,
        REG_DMEM,
        REG_BUF,
        REG_PIM,
        REG_NONE
    } region_e;

    // Returned for reads outside the map
    localparam logic [XLEN-1:0] UNMAPPED_DATA = 32'h0000_0000;

endpackage

//--- logic/spi_bus_bridge.sv
`timescale 1ns/1ps

module spi_bus_bridge (
    input  logic                         clk_i,
    input  logic                         rv_rst_ni,
    input  logic                         sclk_i,
    input  logic                         cs_i,
    input  logic                         mosi_i,
    output logic                         miso_o,
    output logic                         bus_req_o,
    output logic                         bus_we_o,
    output logic [soc_map_pkg::XLEN-1:0] bus_addr_o,
    output logic [soc_map_pkg::XLEN-1:0] bus_wdata_o,
    input  logic [soc_map_pkg::XLEN-1:0] bus_rdata_i
);

    logic [1:0]                   sclk_sync;
    logic [1:0]                   cs_sync;
    logic [1:0]                   mosi_sync;
    logic                         sclk_d;
    logic                         sclk_rise;
    logic                         sclk_fall;
    logic                         mosi_s;
    spi_proto_pkg::frame_state_e  state_q;
    logic [5:0]                   bit_cnt_q;
    int                           frame_bits;
    logic                         last_bit;
    logic [soc_map_pkg::XLEN-1:0] shift_in_q;
    logic [soc_map_pkg::XLEN-1:0] shift_out_q;
    logic [soc_map_pkg::XLEN-1:0] word_in;
    spi_proto_pkg::cmd_e          cmd_in;
    logic                         is_write_q;
    logic                         rd_wait_q;

    // Two-flop synchronizers, cs idles high
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            sclk_sync <= 2'b00;
            cs_sync   <= 2'b11;
            mosi_sync <= 2'b00;
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk_i};
            cs_sync   <= {cs_sync[0], cs_i};
            mosi_sync <= {mosi_sync[0], mosi_i};
            sclk_d    <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_d;
    assign sclk_fall = ~sclk_sync[1] & sclk_d;
    assign mosi_s    = mosi_sync[1];

    // Word including the bit being sampled now
    assign word_in = {shift_in_q[soc_map_pkg::XLEN-2:0], mosi_s};
    assign cmd_in  = spi_proto_pkg::cmd_e'(word_in[spi_proto_pkg::CMD_BITS-1:0]);

    // Length of the current field
    always_comb begin
        case (state_q)
            spi_proto_pkg::FS_CMD:   frame_bits = spi_proto_pkg::CMD_BITS;
            spi_proto_pkg::FS_ADDR:  frame_bits = spi_proto_pkg::ADDR_BITS;
            spi_proto_pkg::FS_WDATA: frame_bits = spi_proto_pkg::DATA_BITS;
            spi_proto_pkg::FS_DUMMY: frame_bits = spi_proto_pkg::DUMMY_BITS;
            spi_proto_pkg::FS_RDATA: frame_bits = spi_proto_pkg::DATA_BITS;
            default:                 frame_bits = 0;
        endcase
    end

    assign last_bit = (bit_cnt_q == 6'(frame_bits - 1));

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            state_q    <= spi_proto_pkg::FS_CMD;
            bit_cnt_q  <= '0;
            is_write_q <= 1'b0;
            bus_req_o  <= 1'b0;
            bus_we_o   <= 1'b0;
            rd_wait_q  <= 1'b0;
            miso_o     <= 1'b0;
        end else begin
            bus_req_o <= 1'b0;
            rd_wait_q <= bus_req_o & ~bus_we_o;
            if (cs_sync[1]) begin
                // Deselect aborts whatever is in flight
                state_q   <= spi_proto_pkg::FS_CMD;
                bit_cnt_q <= '0;
                miso_o    <= 1'b0;
            end else if (sclk_rise) begin
                bit_cnt_q <= last_bit ? 6'd0 : bit_cnt_q + 6'd1;
                case (state_q)
                    spi_proto_pkg::FS_CMD: begin
                        if (last_bit) begin
                            case (cmd_in)
                                spi_proto_pkg::CMD_WRITE: begin
                                    state_q    <= spi_proto_pkg::FS_ADDR;
                                    is_write_q <= 1'b1;
                                end
                                spi_proto_pkg::CMD_READ: begin
                                    state_q    <= spi_proto_pkg::FS_ADDR;
                                    is_write_q <= 1'b0;
                                end
                                default: state_q <= spi_proto_pkg::FS_IGNORE;
                            endcase
                        end
                    end
                    spi_proto_pkg::FS_ADDR: begin
                        if (last_bit && is_write_q) begin
                            state_q <= spi_proto_pkg::FS_WDATA;
                        end else if (last_bit) begin
                            // Read goes out now, data is back well before the dummy bits end
                            state_q   <= spi_proto_pkg::FS_DUMMY;
                            bus_req_o <= 1'b1;
                            bus_we_o  <= 1'b0;
                        end
                    end
                    spi_proto_pkg::FS_WDATA: begin
                        if (last_bit) begin
                            state_q   <= spi_proto_pkg::FS_IGNORE;
                            bus_req_o <= 1'b1;
                            bus_we_o  <= 1'b1;
                        end
                    end
                    spi_proto_pkg::FS_DUMMY: begin
                        if (last_bit) begin
                            state_q <= spi_proto_pkg::FS_RDATA;
                        end
                    end
                    spi_proto_pkg::FS_RDATA: begin
                        if (last_bit) begin
                            state_q <= spi_proto_pkg::FS_IGNORE;
                        end
                    end
                    default: ;
                endcase
            end else if (sclk_fall && state_q == spi_proto_pkg::FS_RDATA) begin
                miso_o <= shift_out_q[soc_map_pkg::XLEN-1];
            end
        end
    end

    // Shift registers and captured fields
    always_ff @(posedge clk_i) begin
        if (sclk_rise) begin
            shift_in_q <= word_in;
            if (last_bit && state_q == spi_proto_pkg::FS_ADDR) begin
                bus_addr_o <= word_in;
            end
            if (last_bit && state_q == spi_proto_pkg::FS_WDATA) begin
                bus_wdata_o <= word_in;
            end
        end
        if (rd_wait_q) begin
            shift_out_q <= bus_rdata_i;
        end else if (sclk_fall && state_q == spi_proto_pkg::FS_RDATA) begin
            shift_out_q <= {shift_out_q[soc_map_pkg::XLEN-2:0], 1'b0};
        end
    end

endmodule

//--- logic/spi_proto_pkg.sv
package spi_proto_pkg;

    typedef enum logic [7:0] {
        CMD_WRITE = 8'h02,
        CMD_READ  = 8'h03
    } cmd_e;

    // Field lengths in sclk cycles
    localparam int CMD_BITS   = 8;
    localparam int ADDR_BITS  = 32;
    localparam int DUMMY_BITS = 8;
    localparam int DATA_BITS  = 32;

    typedef enum logic [2:0] {
        FS_CMD,
        FS_ADDR,
        FS_WDATA,
        FS_DUMMY,
        FS_RDATA,
        FS_IGNORE
    } frame_state_e;

endpackage

//--- logic/sys_bus.sv
`timescale 1ns/1ps

module sys_bus (
    input  logic                         clk_i,
    input  logic                         rv_rst_ni,
    input  logic                         bus_req_i,
    input  logic                         bus_we_i,
    input  logic [soc_map_pkg::XLEN-1:0] bus_addr_i,
    input  logic [soc_map_pkg::XLEN-1:0] bus_wdata_i,
    output logic [soc_map_pkg::XLEN-1:0] bus_rdata_o,
    output logic                         imem_req_o,
    output logic                         imem_we_o,
    output logic                         dmem_req_o,
    output logic                         dmem_we_o,
    output logic                         buf_req_o,
    output logic                         buf_we_o,
    output logic                         pim_req_o,
    output logic                         pim_we_o,
    output logic [soc_map_pkg::XLEN-1:0] mem_addr_o,
    output logic [soc_map_pkg::XLEN-1:0] mem_wdata_o,
    input  logic [soc_map_pkg::XLEN-1:0] imem_rdata_i,
    input  logic [soc_map_pkg::XLEN-1:0] dmem_rdata_i,
    input  logic [soc_map_pkg::XLEN-1:0] buf_rdata_i,
    input  logic [soc_map_pkg::XLEN-1:0] pim_rdata_i
);

    soc_map_pkg::region_e region;
    soc_map_pkg::region_e rd_region_q;

    function automatic logic hit(input logic [soc_map_pkg::XLEN-1:0] addr,
                                 input logic [soc_map_pkg::XLEN-1:0] base);
        hit = addr[soc_map_pkg::XLEN-1:soc_map_pkg::REGION_SHIFT]
              == base[soc_map_pkg::XLEN-1:soc_map_pkg::REGION_SHIFT];
    endfunction

    always_comb begin
        if (hit(bus_addr_i, soc_map_pkg::IMEM_BASE)) begin
            region = soc_map_pkg::REG_IMEM;
        end else if (hit(bus_addr_i, soc_map_pkg::DMEM_BASE)) begin
            region = soc_map_pkg::REG_DMEM;
        end else if (hit(bus_addr_i, soc_map_pkg::BUF_BASE)) begin
            region = soc_map_pkg::REG_BUF;
        end else if (hit(bus_addr_i, soc_map_pkg::PIM_BASE)) begin
            region = soc_map_pkg::REG_PIM;
        end else begin
            region = soc_map_pkg::REG_NONE;
        end
    end

    // Unmapped accesses reach no slave
    assign imem_req_o = bus_req_i & (region == soc_map_pkg::REG_IMEM);
    assign dmem_req_o = bus_req_i & (region == soc_map_pkg::REG_DMEM);
    assign buf_req_o  = bus_req_i & (region == soc_map_pkg::REG_BUF);
    assign pim_req_o  = bus_req_i & (region == soc_map_pkg::REG_PIM);
    assign imem_we_o  = imem_req_o & bus_we_i;
    assign dmem_we_o  = dmem_req_o & bus_we_i;
    assign buf_we_o   = buf_req_o & bus_we_i;
    assign pim_we_o   = pim_req_o & bus_we_i;

    assign mem_addr_o  = bus_addr_i;
    assign mem_wdata_o = bus_wdata_i;

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            rd_region_q <= soc_map_pkg::REG_NONE;
        end else if (bus_req_i && !bus_we_i) begin
            rd_region_q <= region;
        end
    end

    // Slave data arrives one cycle after the strobe
    always_comb begin
        case (rd_region_q)
            soc_map_pkg::REG_IMEM: bus_rdata_o = imem_rdata_i;
            soc_map_pkg::REG_DMEM: bus_rdata_o = dmem_rdata_i;
            soc_map_pkg::REG_BUF:  bus_rdata_o = buf_rdata_i;
            soc_map_pkg::REG_PIM:  bus_rdata_o = pim_rdata_i;
            default:               bus_rdata_o = soc_map_pkg::UNMAPPED_DATA;
        endcase
    end

endmodule

//--- logic/word_sram.sv
`timescale 1ns/1ps

module word_sram (
    input  logic                           clk_i,
    input  logic                           req_i,
    input  logic                           we_i,
    input  logic [soc_map_pkg::MEM_AW-1:0] addr_i,
    input  logic [soc_map_pkg::XLEN-1:0]   wdata_i,
    output logic [soc_map_pkg::XLEN-1:0]   rdata_o
);

    logic [soc_map_pkg::XLEN-1:0] mem [soc_map_pkg::MEM_WORDS];

    // Read port only updates on a read
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end else if (req_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_pim_soc -f verilog.f -o sim_tb \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation ended abnormally"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

//--- verification/pim_soc_checker.sv
`timescale 1ns/1ps

module pim_soc_checker (
    input  logic                         clk_i,
    input  logic                         sclk_i,
    input  logic                         miso_i,
    input  logic                         rd_phase_i,
    input  logic [soc_map_pkg::XLEN-1:0] exp_rdata_i,
    input  logic                         pim_check_i,
    input  logic [soc_map_pkg::XLEN-1:0] exp_pim_addr_i,
    input  logic [soc_map_pkg::XLEN-1:0] exp_pim_wr_i,
    input  logic [soc_map_pkg::XLEN-1:0] pim_addr_i,
    input  logic [soc_map_pkg::XLEN-1:0] pim_wr_i,
    output int                           err_cnt_o,
    output int                           chk_cnt_o
);

    logic [soc_map_pkg::XLEN-1:0] rd_word = '0;
    int                           rd_bits = 0;
    int                           rd_err  = 0;
    int                           rd_chk  = 0;
    int                           pim_err = 0;
    int                           pim_chk = 0;

    assign err_cnt_o = rd_err + pim_err;
    assign chk_cnt_o = rd_chk + pim_chk;

    // Host side of the read data phase, MSB first
    always @(posedge sclk_i) begin
        if (rd_phase_i) begin
            rd_word = {rd_word[soc_map_pkg::XLEN-2:0], miso_i};
            rd_bits = rd_bits + 1;
            if (rd_bits == soc_map_pkg::XLEN) begin
                rd_chk  = rd_chk + 1;
                rd_bits = 0;
                if (rd_word !== exp_rdata_i) begin
                    $display("Fail %0t: read data %h, expected %h",
                             $time, rd_word, exp_rdata_i);
                    rd_err = rd_err + 1;
                end
            end
        end else begin
            rd_bits = 0;
        end
    end

    // PIM pins and idle miso, checked between frames
    always @(posedge clk_i) begin
        if (pim_check_i) begin
            pim_chk = pim_chk + 1;
            if (pim_addr_i !== exp_pim_addr_i || pim_wr_i !== exp_pim_wr_i) begin
                $display("Fail %0t: PIM address/data %h/%h, expected %h/%h",
                         $time, pim_addr_i, pim_wr_i, exp_pim_addr_i, exp_pim_wr_i);
                pim_err = pim_err + 1;
            end
            if (miso_i !== 1'b0) begin
                $display("Fail %0t: miso is %b while deselected, expected 0",
                         $time, miso_i);
                pim_err = pim_err + 1;
            end
        end
    end

endmodule

//--- verification/pim_soc_sva.sv
`timescale 1ns/1ps

module pim_soc_sva (
    input logic clk_i,
    input logic rv_rst_ni,
    input logic bus_req_i,
    input logic imem_req_i,
    input logic dmem_req_i,
    input logic buf_req_i,
    input logic pim_req_i
);

    logic [3:0] strobes;

    assign strobes = {imem_req_i, dmem_req_i, buf_req_i, pim_req_i};

    a_one_slave: assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
        $onehot0(strobes))
        else $error("More than one slave strobe high in the same cycle");

    a_strobe_needs_req: assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
        (strobes != 4'b0000) |-> bus_req_i)
        else $error("Slave strobe high without a bus request");

    // Quiet bus while reset is held
    a_reset_quiet: assert property (@(posedge clk_i)
        !rv_rst_ni |-> (strobes == 4'b0000))
        else $error("Slave strobe high during reset");

endmodule

bind sys_bus pim_soc_sva sva_0 (
    .clk_i      (clk_i),
    .rv_rst_ni  (rv_rst_ni),
    .bus_req_i  (bus_req_i),
    .imem_req_i (imem_req_o),
    .dmem_req_i (dmem_req_o),
    .buf_req_i  (buf_req_o),
    .pim_req_i  (pim_req_o)
);

//--- verification/tb_pim_soc.sv
`timescale 1ns/1ps

module tb_pim_soc;

    localparam int RD_START   = spi_proto_pkg::CMD_BITS + spi_proto_pkg::ADDR_BITS
                                + spi_proto_pkg::DUMMY_BITS;
    localparam int FRAME_BITS = RD_START + spi_proto_pkg::DATA_BITS;
    localparam int WR_BITS    = FRAME_BITS - spi_proto_pkg::DUMMY_BITS;
    localparam int HALF_CYC   = 4;
    localparam int MARGIN     = 2000;

    localparam logic [7:0]  OP_WR  = spi_proto_pkg::CMD_WRITE;
    localparam logic [7:0]  OP_RD  = spi_proto_pkg::CMD_READ;
    localparam logic [7:0]  OP_BAD = 8'h0b;
    localparam logic [31:0] PA     = 32'h4000_0123;
    localparam logic [31:0] PW     = 32'hcafe_1234;

    // A nonzero cut raises cs after that many bits
    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rd;
        logic [31:0] exp_pa;
        logic [31:0] exp_pw;
        int          cut;
        bit          rnd;
    } entry_t;

    entry_t      entries[$];
    logic        clk;
    logic        rv_rst_n;
    logic        sclk;
    logic        cs;
    logic        mosi;
    logic        miso;
    logic [31:0] pim_addr;
    logic [31:0] pim_wr;
    logic [31:0] pim_rd;
    logic        rd_phase;
    logic        pim_check;
    logic [31:0] exp_rd;
    logic [31:0] exp_pa;
    logic [31:0] exp_pw;
    int          err_cnt;
    int          chk_cnt;

    pim_soc_top DUT (
        .clk_i      (clk),
        .rv_rst_ni  (rv_rst_n),
        .sclk_i     (sclk),
        .cs_i       (cs),
        .mosi_i     (mosi),
        .miso_o     (miso),
        .pim_addr_o (pim_addr),
        .pim_wr_o   (pim_wr),
        .pim_rd_i   (pim_rd)
    );

    pim_soc_checker chk_0 (
        .clk_i          (clk),
        .sclk_i         (sclk),
        .miso_i         (miso),
        .rd_phase_i     (rd_phase),
        .exp_rdata_i    (exp_rd),
        .pim_check_i    (pim_check),
        .exp_pim_addr_i (exp_pa),
        .exp_pim_wr_i   (exp_pw),
        .pim_addr_i     (pim_addr),
        .pim_wr_i       (pim_wr),
        .err_cnt_o      (err_cnt),
        .chk_cnt_o      (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_entry(input logic [7:0] op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] rd,
                             input logic [31:0] pa, input logic [31:0] pw,
                             input int cut, input bit rnd);
        entry_t e;
        e = '{op: op, addr: addr, wdata: wdata, exp_rd: rd, exp_pa: pa,
              exp_pw: pw, cut: cut, rnd: rnd};
        entries.push_back(e);
    endtask

    task automatic build_table();
        // IMEM words around an unaligned write in little-endian byte order
        add_entry(OP_WR, 32'h1000_0010, 32'h0302_0100, 32'h0, 32'h0, 32'h0, 0, 0);
        add_entry(OP_WR, 32'h1000_0014, 32'h0706_0504, 32'h0, 32'h0, 32'h0, 0, 0);
        add_entry(OP_WR, 32'h1000_0011, 32'ha1b2_c3d4, 32'h0, 32'h0, 32'h0, 0, 0);
        add_entry(OP_RD, 32'h1000_0011, 32'h0, 32'ha1b2_c3d4, 32'h0, 32'h0, 0, 0);
        add_entry(OP_RD, 32'h1000_0010, 32'h0, 32'hb2c3_d400, 32'h0, 32'h0, 0, 0);
        add_entry(OP_RD, 32'h1000_0014, 32'h0, 32'h0706_05a1, 32'h0, 32'h0, 0, 0);
        // DMEM and buffer at the same offset
        add_entry(OP_WR, 32'h2000_0010, 32'hdead_beef, 32'h0, 32'h0, 32'h0, 0, 0);
        add_entry(OP_WR, 32'h3000_0010, 32'h0bad_f00d, 32'h0, 32'h0, 32'h0, 0, 0);
        add_entry(OP_RD, 32'h2000_0010, 32'h0, 32'hdead_beef, 32'h0, 32'h0, 0, 0);
        add_entry(OP_RD, 32'h3000_0010, 32'h0, 32'h0bad_f00d, 32'h0, 32'h0, 0, 0);
        add_entry(OP_WR, PA, PW, 32'h0, PA, PW, 0, 0);
        add_entry(OP_RD, 32'h4000_0000, 32'h0, 32'h0, PA, PW, 0, 1);
        // Unmapped region
        add_entry(OP_RD, 32'h5000_0010, 32'h0, soc_map_pkg::UNMAPPED_DATA, PA, PW, 0, 0);
        add_entry(OP_WR, 32'h5000_0010, 32'hffff_ffff, 32'h0, PA, PW, 0, 0);
        add_entry(OP_RD, 32'h2000_0010, 32'h0, 32'hdead_beef, PA, PW, 0, 0);
        add_entry(OP_RD, 32'h3000_0010, 32'h0, 32'h0bad_f00d, PA, PW, 0, 0);
        add_entry(OP_RD, 32'h1000_0011, 32'h0, 32'ha1b2_c3d4, PA, PW, 0, 0);
        // Unknown opcode and then writes cut short
        add_entry(OP_BAD, 32'h2000_0010, 32'h1234_5678, 32'h0, PA, PW, 0, 0);
        add_entry(OP_WR, 32'h2000_0010, 32'h5555_5555, 32'h0, PA, PW, 60, 0);
        add_entry(OP_WR, 32'h4000_0200, 32'h0f0f_0f0f, 32'h0, PA, PW, WR_BITS - 1, 0);
        add_entry(OP_RD, 32'h2000_0010, 32'h0, 32'hdead_beef, PA, PW, 0, 0);
        add_entry(OP_RD, 32'h4000_0000, 32'h0, 32'h0, PA, PW, 0, 1);
    endtask

    // Mode 0 and MSB first with each sclk phase held HALF_CYC clocks
    task automatic send_frame(input entry_t e);
        logic [FRAME_BITS-1:0] bits;
        int                    n;
        int                    stop;
        bits = {e.op, e.addr, e.wdata, 8'h00};
        n    = (e.op == OP_RD) ? FRAME_BITS : WR_BITS;
        stop = (e.cut != 0) ? e.cut : n;
        cs <= 1'b0;
        repeat (HALF_CYC) @(posedge clk);
        for (int i = 0; i < stop; i++) begin
            sclk     <= 1'b0;
            mosi     <= bits[FRAME_BITS-1-i];
            rd_phase <= (e.op == OP_RD) && (i >= RD_START);
            repeat (HALF_CYC) @(posedge clk);
            sclk <= 1'b1;
            repeat (HALF_CYC) @(posedge clk);
        end
        sclk     <= 1'b0;
        rd_phase <= 1'b0;
        repeat (HALF_CYC) @(posedge clk);
        cs <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic pulse_pim_check();
        pim_check <= 1'b1;
        @(posedge clk);
        pim_check <= 1'b0;
    endtask

    initial begin
        logic [31:0] rnd_val;
        void'($urandom(34106));
        rv_rst_n  = 1'b0;
        sclk      = 1'b0;
        cs        = 1'b1;
        mosi      = 1'b0;
        pim_rd    = 32'h0;
        rd_phase  = 1'b0;
        pim_check = 1'b0;
        exp_rd    = 32'h0;
        exp_pa    = 32'h0;
        exp_pw    = 32'h0;
        build_table();
        repeat (5) @(posedge clk);
        rv_rst_n <= 1'b1;
        @(posedge clk);
        pulse_pim_check();
        foreach (entries[i]) begin
            rnd_val = $urandom;
            pim_rd <= rnd_val;
            exp_rd <= entries[i].rnd ? rnd_val : entries[i].exp_rd;
            exp_pa <= entries[i].exp_pa;
            exp_pw <= entries[i].exp_pw;
            send_frame(entries[i]);
            pulse_pim_check();
        end
        @(posedge clk);
        $display("Run complete: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        @(posedge rv_rst_n);
        limit = entries.size() * FRAME_BITS * 2 * HALF_CYC + MARGIN;
        repeat (limit) @(posedge clk);
        $display("Timeout: the frames did not complete within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule

//--- verilog.f
logic/soc_map_pkg.sv
logic/spi_proto_pkg.sv
logic/spi_bus_bridge.sv
logic/sys_bus.sv
logic/imem_lane_sram.sv
logic/word_sram.sv
logic/pim_port.sv
logic/pim_soc_top.sv
verification/pim_soc_sva.sv
verification/pim_soc_checker.sv
verification/tb_pim_soc.sv
